// File: logic/sonar_settings.svh
`ifndef SONAR_SETTINGS_SVH
`define SONAR_SETTINGS_SVH

// ----------------------------------------------------------
// External RAM
// ----------------------------------------------------------
`define RAM_DATA_W 16 // Data bus width
`define RAM_ADDR_W 19 // Address bus width

// ----------------------------------------------------------
// Acquisition
// ----------------------------------------------------------
`define ADC_DATA_W         10 // ADC sample width
`define ACQ_LINES_W        8  // Line count width
`define ACQ_WORDS_PER_LINE 16 // Samples per line, short for sim

// Test pattern region, starts at address 0
`define FILL_WORDS 256

// Trigger must hold this many cycles
`define DEBOUNCE_DELAY 8

`endif

// File: logic/sonar_pkg.sv
`include "sonar_settings.svh"

package sonar_pkg;

    // Bus payload types
    typedef logic [`RAM_ADDR_W-1:0]  ram_addr_t;  // One RAM address
    typedef logic [`RAM_DATA_W-1:0]  ram_data_t;  // One RAM word
    typedef logic [`ADC_DATA_W-1:0]  adc_data_t;  // One ADC sample
    typedef logic [`ACQ_LINES_W-1:0] acq_lines_t; // Lines per acquisition

    // Fill pattern opcode
    typedef enum logic {
        FILL_INC, // Data follows address
        FILL_DEC  // Data is inverted address
    } fill_mode_e;

    // Filler FSM
    typedef enum logic {
        FILL_IDLE,
        FILL_RUN
    } fill_state_e;

    // Acquisition FSM
    typedef enum logic {
        ACQ_IDLE,
        ACQ_RUN
    } acq_state_e;

endpackage

// File: logic/ram_wr_if.sv
`include "sonar_settings.svh"

// One writer's request towards the RAM port
interface ram_wr_if;

    logic                   active; // Writer owns a sequence
    logic                   wen;    // One write per high cycle
    logic [`RAM_ADDR_W-1:0] addr;
    logic [`RAM_DATA_W-1:0] wdata;

    // Writer side
    modport src (output active, output wen, output addr, output wdata);

    // RAM port side
    modport sink (input active, input wen, input addr, input wdata);

endinterface

// File: logic/trig_conditioner.sv
`include "sonar_settings.svh"

module trig_conditioner (
    input  logic sys_clk,
    input  logic sys_rst,
    input  logic trig_in,   // Raw board trigger, async
    output logic trig_pulse // One cycle per debounced rising edge
);

    localparam int CNT_W = $clog2(`DEBOUNCE_DELAY);

    logic [1:0]       trig_sync; // Two-flop synchronizer
    logic [CNT_W-1:0] stable_cnt;
    logic             trig_level; // Debounced level
    logic             trig_level_q;

    // ----------------------------------------------------------
    // Synchronize and debounce
    // ----------------------------------------------------------
    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            trig_sync  <= '0;
            stable_cnt <= '0;
            trig_level <= 1'b0;
        end else begin
            trig_sync <= {trig_sync[0], trig_in};
            if (trig_sync[1] == trig_level) begin
                stable_cnt <= '0; // Glitch gone, start over
            end else if (stable_cnt == CNT_W'(`DEBOUNCE_DELAY - 1)) begin
                trig_level <= trig_sync[1]; // New value held long enough
                stable_cnt <= '0;
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

    // Edge detect on debounced level
    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) trig_level_q <= 1'b0;
        else         trig_level_q <= trig_level;
    end

    assign trig_pulse = trig_level & ~trig_level_q;

endmodule

// File: logic/ram_filler.sv
`include "sonar_settings.svh"

module ram_filler (
    input  logic                 sys_clk,
    input  logic                 sys_rst,
    input  logic                 fill_start, // Start pulse, ignored while busy
    input  sonar_pkg::fill_mode_e fill_mode, // Pattern select, taken at start
    output logic                 fill_done,  // Pulse after last write
    ram_wr_if.src                wr
);

    import sonar_pkg::*;

    fill_state_e state;
    fill_mode_e  mode_q;
    ram_addr_t   waddr;
    logic        last_addr;

    assign last_addr = (waddr == ram_addr_t'(`FILL_WORDS - 1));

    // ----------------------------------------------------------
    // FSM and address counter
    // ----------------------------------------------------------
    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            state     <= FILL_IDLE;
            mode_q    <= FILL_INC;
            waddr     <= '0;
            fill_done <= 1'b0;
        end else begin
            fill_done <= 1'b0;
            case (state)
                FILL_IDLE: begin
                    if (fill_start) begin
                        state  <= FILL_RUN;
                        mode_q <= fill_mode;
                        waddr  <= '0; // Region always starts at 0
                    end
                end
                FILL_RUN: begin
                    if (last_addr) begin
                        state     <= FILL_IDLE;
                        fill_done <= 1'b1;
                    end else begin
                        waddr <= waddr + 1'b1;
                    end
                end
                default: state <= FILL_IDLE;
            endcase
        end
    end

    // One write every cycle in FILL_RUN
    assign wr.active = (state == FILL_RUN);
    assign wr.wen    = (state == FILL_RUN);
    assign wr.addr   = waddr;

    // Pattern from the low address bits
    assign wr.wdata = (mode_q == FILL_INC) ? ram_data_t'(waddr)
                                           : ~ram_data_t'(waddr);

endmodule

// File: logic/acq_writer.sv
`include "sonar_settings.svh"

module acq_writer (
    input  logic                  sys_clk,
    input  logic                  sys_rst,
    input  logic                  acq_start,  // Start strobe
    input  logic                  trig_pulse, // Start from external trigger
    input  sonar_pkg::acq_lines_t acq_lines,  // Lines to store, 0 means none
    input  sonar_pkg::adc_data_t  adc_d,      // ADC bus
    output logic                  acq_done,   // Pulse after last write
    ram_wr_if.src                 wr
);

    import sonar_pkg::*;

    localparam int WORD_CNT_W = $clog2(`ACQ_WORDS_PER_LINE);
    localparam int WORD_LAST  = `ACQ_WORDS_PER_LINE - 1;

    acq_state_e             state;
    adc_data_t              adc_q;    // Sample from previous cycle
    acq_lines_t             lines_q;  // Line count of this run
    acq_lines_t             line_cnt;
    logic [WORD_CNT_W-1:0]  word_cnt; // Position inside the line
    ram_addr_t              waddr;
    logic                   start;
    logic                   word_last;
    logic                   line_last;

    assign start     = acq_start | trig_pulse;
    assign word_last = (word_cnt == WORD_CNT_W'(WORD_LAST));
    assign line_last = (line_cnt == lines_q - 1'b1);

    // ADC input flop, free running
    always_ff @(posedge sys_clk) begin
        adc_q <= adc_d;
    end

    // ----------------------------------------------------------
    // Run control and counters
    // ----------------------------------------------------------
    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            state    <= ACQ_IDLE;
            lines_q  <= '0;
            line_cnt <= '0;
            word_cnt <= '0;
            waddr    <= '0;
            acq_done <= 1'b0;
        end else begin
            acq_done <= 1'b0;
            case (state)
                ACQ_IDLE: begin
                    if (start && (acq_lines != '0)) begin
                        state    <= ACQ_RUN;
                        lines_q  <= acq_lines;
                        line_cnt <= '0;
                        word_cnt <= '0;
                        waddr    <= '0;
                    end
                end
                ACQ_RUN: begin
                    waddr <= waddr + 1'b1; // Continuous across lines
                    if (word_last) begin
                        word_cnt <= '0;
                        if (line_last) begin
                            state    <= ACQ_IDLE;
                            acq_done <= 1'b1;
                        end else begin
                            line_cnt <= line_cnt + 1'b1;
                        end
                    end else begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end
                default: state <= ACQ_IDLE;
            endcase
        end
    end

    assign wr.active = (state == ACQ_RUN);
    assign wr.wen    = (state == ACQ_RUN); // No gaps between lines
    assign wr.addr   = waddr;
    assign wr.wdata  = ram_data_t'(adc_q); // Zero-extended sample

endmodule

// File: logic/ram_port.sv
module ram_port (
    input  logic                 sys_clk,
    input  logic                 sys_rst,
    ram_wr_if.sink               fill_wr, // Test pattern filler, wins
    ram_wr_if.sink               acq_wr,  // Acquisition writer
    output sonar_pkg::ram_addr_t ram_addr,
    output sonar_pkg::ram_data_t ram_wdata,
    output logic                 ram_we_n // Active low strobe
);

    import sonar_pkg::*;

    logic      sel_fill;
    logic      sel_wen;
    ram_addr_t sel_addr;
    ram_data_t sel_wdata;

    // ----------------------------------------------------------
    // Writer select
    // ----------------------------------------------------------
    // Filler owns the port for its whole sequence
    assign sel_fill = fill_wr.active;

    always_comb begin
        if (sel_fill) begin
            sel_wen   = fill_wr.wen;
            sel_addr  = fill_wr.addr;
            sel_wdata = fill_wr.wdata;
        end else begin
            sel_wen   = acq_wr.wen; // Dropped while filler busy
            sel_addr  = acq_wr.addr;
            sel_wdata = acq_wr.wdata;
        end
    end

    // ----------------------------------------------------------
    // Pin flops
    // ----------------------------------------------------------
    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            ram_we_n  <= 1'b1;
            ram_addr  <= '0;
            ram_wdata <= '0;
        end else begin
            ram_we_n <= ~sel_wen; // Low for one cycle per write
            if (sel_wen) begin
                // Hold last write between strobes
                ram_addr  <= sel_addr;
                ram_wdata <= sel_wdata;
            end
        end
    end

endmodule

// File: logic/sonar_top.sv
module sonar_top (
    input  logic                  sys_clk,
    input  logic                  sys_rst,
    // Test pattern fill
    input  logic                  fill_start,
    input  sonar_pkg::fill_mode_e fill_mode,
    output logic                  fill_active,
    output logic                  fill_done,
    // Acquisition
    input  logic                  acq_start,
    input  sonar_pkg::acq_lines_t acq_lines,
    input  logic                  trig_in,  // Board trigger pin
    output logic                  acq_busy,
    output logic                  acq_done,
    // ADC
    output logic                  adc_clk,
    input  sonar_pkg::adc_data_t  adc_d,
    // External RAM, write only
    output sonar_pkg::ram_addr_t  ram_addr,
    output sonar_pkg::ram_data_t  ram_wdata,
    output logic                  ram_we_n
);

    logic trig_pulse;

    ram_wr_if fill_bus ();
    ram_wr_if acq_bus ();

    // ----------------------------------------------------------
    // Trigger and writers
    // ----------------------------------------------------------
    trig_conditioner u_trig_conditioner (
        .sys_clk    (sys_clk),
        .sys_rst    (sys_rst),
        .trig_in    (trig_in),
        .trig_pulse (trig_pulse)
    );

    ram_filler u_ram_filler (
        .sys_clk    (sys_clk),
        .sys_rst    (sys_rst),
        .fill_start (fill_start),
        .fill_mode  (fill_mode),
        .fill_done  (fill_done),
        .wr         (fill_bus.src)
    );

    acq_writer u_acq_writer (
        .sys_clk    (sys_clk),
        .sys_rst    (sys_rst),
        .acq_start  (acq_start),
        .trig_pulse (trig_pulse), // Same effect as acq_start
        .acq_lines  (acq_lines),
        .adc_d      (adc_d),
        .acq_done   (acq_done),
        .wr         (acq_bus.src)
    );

    // ----------------------------------------------------------
    // RAM pins
    // ----------------------------------------------------------
    ram_port u_ram_port (
        .sys_clk   (sys_clk),
        .sys_rst   (sys_rst),
        .fill_wr   (fill_bus.sink),
        .acq_wr    (acq_bus.sink),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_we_n  (ram_we_n)
    );

    assign fill_active = fill_bus.active;
    assign acq_busy    = acq_bus.active;
    assign adc_clk     = sys_clk; // ADC runs on system clock

endmodule

// File: tb/tb_sonar_top.sv
`include "sonar_settings.svh"

module tb_sonar_top;

    import sonar_pkg::*;

    // Cycle budget of all tests plus 20% margin
    localparam int TEST_CYCLES = 20 + 2 * (`FILL_WORDS + 10)
                                 + 2 * (4 * `ACQ_WORDS_PER_LINE + 10) + 6 * `DEBOUNCE_DELAY + 60;
    localparam int LIMIT = TEST_CYCLES * 6 / 5;

    logic       sys_clk = 1'b0;
    logic       sys_rst;
    logic       fill_start, acq_start, trig_in;
    fill_mode_e fill_mode;
    acq_lines_t acq_lines;
    adc_data_t  adc_d;
    logic       fill_active, fill_done, acq_busy, acq_done, adc_clk, ram_we_n;
    ram_addr_t  ram_addr;
    ram_data_t  ram_wdata;

    integer     seed = 32'hacfa;
    int         err_cnt = 0;
    int         cycle_cnt = 0;
    acq_lines_t lines_a, lines_b; // Line counts of the two acquisitions

    // ----------------------------------------------------------
    // Model memory
    // ----------------------------------------------------------
    ram_data_t  mem [0:`FILL_WORDS-1];
    ram_data_t  acq_exp [0:`FILL_WORDS-1]; // Sample expected per address
    int         hits [0:`FILL_WORDS-1];
    int         wr_cnt, fill_done_cnt, acq_done_cnt;
    int         fill_act_cnt, acq_busy_cnt; // Cycles with each writer active
    adc_data_t  adc_hist [$]; // Driven samples with newest first

    sonar_top u_sonar_top (
        .sys_clk (sys_clk), .sys_rst (sys_rst),
        .fill_start (fill_start), .fill_mode (fill_mode), .fill_active (fill_active),
        .fill_done (fill_done), .acq_start (acq_start), .acq_lines (acq_lines),
        .trig_in (trig_in), .acq_busy (acq_busy), .acq_done (acq_done),
        .adc_clk (adc_clk), .adc_d (adc_d),
        .ram_addr (ram_addr), .ram_wdata (ram_wdata), .ram_we_n (ram_we_n)
    );

    always #5 sys_clk = ~sys_clk;

    // New ADC sample every cycle
    always @(posedge sys_clk) begin
        #1;
        adc_d = adc_data_t'($random(seed));
        adc_hist.push_front(adc_d);
        if (adc_hist.size() > 3) void'(adc_hist.pop_back());
    end

    // ADC clock follows the system clock in both phases
    always @(sys_clk) begin
        #1;
        compare_value("adc_clk", sys_clk, adc_clk);
    end

    // RAM pins are stable at the falling edge
    always @(negedge sys_clk) begin
        int idx;
        idx = int'(ram_addr);
        if (!ram_we_n) begin
            wr_cnt++;
            if (idx < `FILL_WORDS) begin
                mem[idx] = ram_wdata;
                hits[idx]++;
                if (adc_hist.size() > 2) begin
                    acq_exp[idx] = ram_data_t'(adc_hist[2]); // Two cycles back
                end
            end else begin
                $display("Write outside the model memory at address %0h", ram_addr);
                err_cnt++;
            end
        end
        if (fill_done) fill_done_cnt++;
        if (acq_done) acq_done_cnt++;
        if (fill_active) fill_act_cnt++;
        if (acq_busy) acq_busy_cnt++;
    end

    // Run limit
    always @(posedge sys_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= LIMIT) begin
            $display("Timeout after %0d cycles, a test never finished", cycle_cnt);
            $display("Errors: %0d", err_cnt);
            $display("Simulation failed");
            $finish;
        end
    end

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------
    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (exp !== act) begin
            $display("** Error %s: expected %0h, actual %0h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic next_cycle(); // Just past the rising edge
        @(posedge sys_clk);
        #1;
    endtask

    task automatic check_idle(input string name);
        compare_value({name, " ram_we_n"}, 1, ram_we_n);
        compare_value({name, " fill_active"}, 0, fill_active);
        compare_value({name, " acq_busy"}, 0, acq_busy);
        compare_value({name, " fill_done"}, 0, fill_done);
        compare_value({name, " acq_done"}, 0, acq_done);
        compare_value({name, " ram_addr"}, 0, ram_addr);
        compare_value({name, " ram_wdata"}, 0, ram_wdata);
    endtask

    task automatic clear_log();
        for (int i = 0; i < `FILL_WORDS; i++) hits[i] = 0;
        wr_cnt = 0;
        fill_done_cnt = 0;
        acq_done_cnt = 0;
        fill_act_cnt = 0;
        acq_busy_cnt = 0;
    endtask

    // Every address from 0 written once with the expected word
    task automatic verify_log(input string name, input int words, input bit acq,
                              input fill_mode_e mode, input int done_cnt);
        ram_data_t exp;
        compare_value({name, " write count"}, words, wr_cnt);
        compare_value({name, " done pulses"}, 1, done_cnt);
        compare_value({name, " fill_active cycles"}, acq ? 0 : words, fill_act_cnt);
        compare_value({name, " acq_busy cycles"}, acq ? words : 0, acq_busy_cnt);
        for (int a = 0; a < words; a++) begin
            if (acq) exp = acq_exp[a];
            else if (mode == FILL_INC) exp = ram_data_t'(a);
            else exp = ~ram_data_t'(a);
            compare_value($sformatf("%s hits @%0d", name, a), 1, hits[a]);
            compare_value($sformatf("%s data @%0d", name, a), exp, mem[a]);
        end
    endtask

    // ----------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------
    initial begin
        sys_rst = 1'b1;
        fill_start = 1'b0;
        fill_mode = FILL_INC;
        acq_start = 1'b0;
        acq_lines = '0;
        trig_in = 1'b0;
        adc_d = '0;
        lines_a = acq_lines_t'(($random(seed) & 3) + 1); // 1 to 4 lines
        lines_b = acq_lines_t'(($random(seed) & 3) + 1);
        clear_log();
        repeat (10) begin
            next_cycle();
            check_idle("reset");
        end
        sys_rst = 1'b0;
        repeat (3) begin
            next_cycle();
            check_idle("after reset");
        end

        // Incrementing fill with a second start mid-run
        clear_log();
        fill_start = 1'b1;
        next_cycle();
        fill_start = 1'b0;
        repeat (50) next_cycle();
        fill_start = 1'b1;
        fill_mode = FILL_DEC; // Must not be taken
        next_cycle();
        fill_start = 1'b0;
        while (!fill_done) next_cycle();
        repeat (3) next_cycle();
        verify_log("fill inc", `FILL_WORDS, 1'b0, FILL_INC, fill_done_cnt);

        // Decrementing fill and its latency
        clear_log();
        fill_mode = FILL_DEC;
        fill_start = 1'b1;
        next_cycle();
        fill_start = 1'b0;
        compare_value("fill latency 1 cycle", 1, ram_we_n);
        next_cycle();
        compare_value("fill latency 2 cycles", 0, ram_we_n);
        while (!fill_done) next_cycle();
        repeat (3) next_cycle();
        verify_log("fill dec", `FILL_WORDS, 1'b0, FILL_DEC, fill_done_cnt);

        // Acquisition by strobe
        clear_log();
        acq_lines = lines_a;
        acq_start = 1'b1;
        next_cycle();
        acq_start = 1'b0;
        while (!acq_done) next_cycle();
        repeat (3) next_cycle();
        verify_log("acq strobe", lines_a * `ACQ_WORDS_PER_LINE, 1'b1, FILL_INC, acq_done_cnt);

        // Short trigger glitch is filtered
        clear_log();
        acq_lines = lines_b;
        trig_in = 1'b1;
        repeat (`DEBOUNCE_DELAY - 3) next_cycle();
        trig_in = 1'b0;
        repeat (4 * `DEBOUNCE_DELAY) next_cycle();
        compare_value("trig glitch writes", 0, wr_cnt);
        compare_value("trig glitch done", 0, acq_done_cnt);

        // Held trigger starts one run
        trig_in = 1'b1;
        while (!acq_done) next_cycle();
        trig_in = 1'b0;
        repeat (4 * `DEBOUNCE_DELAY) next_cycle();
        verify_log("acq trigger", lines_b * `ACQ_WORDS_PER_LINE, 1'b1, FILL_INC, acq_done_cnt);

        $display("Errors: %0d", err_cnt);
        if (err_cnt == 0) $display("Simulation passed");
        else $display("Simulation failed");
        $finish;
    end

endmodule

// File: flist.f
+incdir+logic
logic/sonar_pkg.sv
logic/ram_wr_if.sv
logic/trig_conditioner.sv
logic/ram_filler.sv
logic/acq_writer.sv
logic/ram_port.sv
logic/sonar_top.sv
tb/tb_sonar_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_sonar_top -f flist.f -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
